//--- common/uop_pkg.sv
// ##########################################################################
// shared types, operation enum, depths and reset pc for the micro-op pipe
// ##########################################################################
package uop_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;

    // immediate already shifted into place
    typedef logic [31:0] imm_t;

    // holds 0..QUEUE_DEPTH
    typedef logic [2:0]  credit_cnt_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lui,
        op_auipc,
        op_ebreak,
        op_nop
    } alu_op_t;

    // fetch buffer entries, also initial source credits
    localparam int FETCH_DEPTH = 2;
    // micro-op queue entries, also initial decode credits
    localparam int QUEUE_DEPTH = 4;

    localparam pc_t RESET_PC = 32'h80000000;

    // rv32i major opcodes in use
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // full ebreak encoding, matched as one word
    localparam word_t EBREAK_WORD = 32'h00100073;

endpackage

//--- rtl/reg_file.sv
// ##########################################################################
// register file: x1..x31, two combinational reads, one write
// ##########################################################################
module reg_file (
    input  logic              CLK,
    input  logic              rst_n,
    input  uop_pkg::reg_idx_t rs1,
    input  uop_pkg::reg_idx_t rs2,
    output uop_pkg::word_t    rdata1,
    output uop_pkg::word_t    rdata2,
    input  logic              we,
    input  uop_pkg::reg_idx_t waddr,
    input  uop_pkg::word_t    wdata
);
    import uop_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // reads show the value before this cycle's write
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- fetch/fetch_stage.sv
// ##########################################################################
// fetch stage: two-entry instruction buffer with pc tagging
// and credit return toward the instruction source
// ##########################################################################
module fetch_stage (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           instr_valid,
    input  uop_pkg::word_t instr,
    output logic           instr_credit,
    output logic           fetch_valid,
    output uop_pkg::word_t fetch_instr,
    output uop_pkg::pc_t   fetch_pc,
    input  logic           fetch_pop
);
    import uop_pkg::*;

    // entry storage
    word_t instr_buf [FETCH_DEPTH];
    pc_t   pc_buf    [FETCH_DEPTH];

    logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FETCH_DEPTH+1)-1:0] count;
    // pc for the next accepted word
    pc_t next_pc;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            next_pc <= RESET_PC;
        end else begin
            if (instr_valid) begin
                wr_ptr  <= wr_ptr + 1'b1;
                next_pc <= next_pc + 32'd4;
            end
            if (fetch_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({instr_valid, fetch_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload, written at the tail
    always_ff @(posedge CLK) begin
        if (instr_valid) begin
            instr_buf[wr_ptr] <= instr;
            pc_buf[wr_ptr]    <= next_pc;
        end
    end

    // head entry toward decode
    assign fetch_valid = (count != '0);
    assign fetch_instr = instr_buf[rd_ptr];
    assign fetch_pc    = pc_buf[rd_ptr];

    // one credit back per entry leaving
    assign instr_credit = fetch_pop;

    // source must hold a credit before sending
    a_no_push_when_full: assert property (@(posedge CLK) disable iff (!rst_n)
        instr_valid |-> (count != FETCH_DEPTH));

endmodule

//--- decode/decode_stage.sv
// ##########################################################################
// decode stage: rv32i subset decoder, registered micro-op output and
// credit counter toward the micro-op queue
// ##########################################################################
module decode_stage (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  uop_pkg::word_t    fetch_instr,
    input  uop_pkg::pc_t      fetch_pc,
    output logic              fetch_pop,
    output logic              enq_valid,
    output uop_pkg::alu_op_t  uop_op,
    output uop_pkg::reg_idx_t uop_rd,
    output uop_pkg::reg_idx_t uop_rs1,
    output uop_pkg::reg_idx_t uop_rs2,
    output uop_pkg::imm_t     uop_imm,
    output logic              uop_use_imm,
    output logic              uop_writes_rd,
    output uop_pkg::pc_t      uop_pc,
    input  logic              uop_credit
);
    import uop_pkg::*;

    credit_cnt_t credits;

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;

    // decoded micro-op before the register
    alu_op_t dec_op;
    imm_t    dec_imm;
    logic    dec_use_imm;
    logic    dec_writes;

    assign opcode = fetch_instr[6:0];
    assign funct3 = fetch_instr[14:12];
    assign funct7 = fetch_instr[31:25];
    assign rd     = fetch_instr[11:7];

    always_comb begin
        dec_op      = op_nop;
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec_op = op_add;
                        3'b100:  dec_op = op_xor;
                        3'b110:  dec_op = op_or;
                        3'b111:  dec_op = op_and;
                        default: dec_op = op_nop;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_op = op_sub;
                end
            end
            OPC_OP_IMM: begin
                // sign-extended 12-bit immediate
                dec_imm     = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
                dec_use_imm = 1'b1;
                case (funct3)
                    3'b000:  dec_op = op_add;
                    3'b100:  dec_op = op_xor;
                    3'b110:  dec_op = op_or;
                    3'b111:  dec_op = op_and;
                    default: dec_op = op_nop;
                endcase
            end
            OPC_LUI: begin
                dec_op  = op_lui;
                dec_imm = {fetch_instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                dec_op  = op_auipc;
                dec_imm = {fetch_instr[31:12], 12'b0};
            end
            default: begin
                if (fetch_instr == EBREAK_WORD) begin
                    dec_op = op_ebreak;
                end
            end
        endcase
    end

    // nop and ebreak never write, x0 writes dropped here
    assign dec_writes = (dec_op != op_nop) && (dec_op != op_ebreak) && (rd != '0);

    // consume only with a queue slot reserved
    assign fetch_pop = fetch_valid && (credits != '0);

    // credit spent at pop, queue write follows a cycle later
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            credits   <= credit_cnt_t'(QUEUE_DEPTH);
            enq_valid <= 1'b0;
        end else begin
            enq_valid <= fetch_pop;
            case ({fetch_pop, uop_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // micro-op payload
    always_ff @(posedge CLK) begin
        if (fetch_pop) begin
            uop_op        <= dec_op;
            uop_rd        <= rd;
            uop_rs1       <= fetch_instr[19:15];
            uop_rs2       <= fetch_instr[24:20];
            uop_imm       <= dec_imm;
            uop_use_imm   <= dec_use_imm;
            uop_writes_rd <= dec_writes;
            uop_pc        <= fetch_pc;
        end
    end

    // queue returns at most what was spent
    a_credit_bound: assert property (@(posedge CLK) disable iff (!rst_n)
        credits <= QUEUE_DEPTH);

endmodule

//--- queue/uop_queue.sv
// ##########################################################################
// micro-op queue: circular fifo between decode and execute,
// one credit back to decode per pop
// ##########################################################################
module uop_queue (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              enq_valid,
    input  uop_pkg::alu_op_t  uop_op,
    input  uop_pkg::reg_idx_t uop_rd,
    input  uop_pkg::reg_idx_t uop_rs1,
    input  uop_pkg::reg_idx_t uop_rs2,
    input  uop_pkg::imm_t     uop_imm,
    input  logic              uop_use_imm,
    input  logic              uop_writes_rd,
    input  uop_pkg::pc_t      uop_pc,
    output logic              deq_ready,
    input  logic              deq_pop,
    output uop_pkg::alu_op_t  head_op,
    output uop_pkg::reg_idx_t head_rd,
    output uop_pkg::reg_idx_t head_rs1,
    output uop_pkg::reg_idx_t head_rs2,
    output uop_pkg::imm_t     head_imm,
    output logic              head_use_imm,
    output logic              head_writes_rd,
    output uop_pkg::pc_t      head_pc,
    output logic              uop_credit
);
    import uop_pkg::*;

    // one array per micro-op field
    alu_op_t  q_op        [QUEUE_DEPTH];
    reg_idx_t q_rd        [QUEUE_DEPTH];
    reg_idx_t q_rs1       [QUEUE_DEPTH];
    reg_idx_t q_rs2       [QUEUE_DEPTH];
    imm_t     q_imm       [QUEUE_DEPTH];
    logic     q_use_imm   [QUEUE_DEPTH];
    logic     q_writes_rd [QUEUE_DEPTH];
    pc_t      q_pc        [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
    credit_cnt_t                    count;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_valid, deq_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_valid) begin
            q_op[wr_ptr]        <= uop_op;
            q_rd[wr_ptr]        <= uop_rd;
            q_rs1[wr_ptr]       <= uop_rs1;
            q_rs2[wr_ptr]       <= uop_rs2;
            q_imm[wr_ptr]       <= uop_imm;
            q_use_imm[wr_ptr]   <= uop_use_imm;
            q_writes_rd[wr_ptr] <= uop_writes_rd;
            q_pc[wr_ptr]        <= uop_pc;
        end
    end

    // head visible once count is up
    assign deq_ready      = (count != '0);
    assign head_op        = q_op[rd_ptr];
    assign head_rd        = q_rd[rd_ptr];
    assign head_rs1       = q_rs1[rd_ptr];
    assign head_rs2       = q_rs2[rd_ptr];
    assign head_imm       = q_imm[rd_ptr];
    assign head_use_imm   = q_use_imm[rd_ptr];
    assign head_writes_rd = q_writes_rd[rd_ptr];
    assign head_pc        = q_pc[rd_ptr];

    // freed slot goes straight back to decode
    assign uop_credit = deq_pop;

    // decode credits keep writes off a full queue
    a_no_write_full: assert property (@(posedge CLK) disable iff (!rst_n)
        enq_valid |-> (count != QUEUE_DEPTH));
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n)
        deq_pop |-> (count != '0));

endmodule

//--- execute/execute_stage.sv
// ##########################################################################
// execute stage: operand read with writeback forwarding, alu,
// writeback register and sticky halt
// ##########################################################################
module execute_stage (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              deq_ready,
    output logic              deq_pop,
    input  uop_pkg::alu_op_t  head_op,
    input  uop_pkg::reg_idx_t head_rd,
    input  uop_pkg::reg_idx_t head_rs1,
    input  uop_pkg::reg_idx_t head_rs2,
    input  uop_pkg::imm_t     head_imm,
    input  logic              head_use_imm,
    input  logic              head_writes_rd,
    input  uop_pkg::pc_t      head_pc,
    output uop_pkg::reg_idx_t rf_rs1,
    output uop_pkg::reg_idx_t rf_rs2,
    input  uop_pkg::word_t    rf_rdata1,
    input  uop_pkg::word_t    rf_rdata2,
    output logic              wb_valid,
    output uop_pkg::reg_idx_t wb_rd,
    output uop_pkg::word_t    wb_data,
    output logic              halt
);
    import uop_pkg::*;

    logic  fwd1;
    logic  fwd2;
    word_t src1;
    word_t src2;
    word_t op_b;
    word_t alu_result;

    // one micro-op per cycle until halted
    assign deq_pop = deq_ready && !halt;

    assign rf_rs1 = head_rs1;
    assign rf_rs2 = head_rs2;

    // file write lands this edge, so the read is stale
    assign fwd1 = wb_valid && (wb_rd == head_rs1) && (head_rs1 != '0);
    assign fwd2 = wb_valid && (wb_rd == head_rs2) && (head_rs2 != '0);
    assign src1 = fwd1 ? wb_data : rf_rdata1;
    assign src2 = fwd2 ? wb_data : rf_rdata2;

    assign op_b = head_use_imm ? head_imm : src2;

    always_comb begin
        case (head_op)
            op_add:   alu_result = src1 + op_b;
            op_sub:   alu_result = src1 - op_b;
            op_and:   alu_result = src1 & op_b;
            op_or:    alu_result = src1 | op_b;
            op_xor:   alu_result = src1 ^ op_b;
            op_lui:   alu_result = head_imm;
            op_auipc: alu_result = head_pc + head_imm;
            // ebreak and nop produce nothing
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            halt     <= 1'b0;
        end else begin
            wb_valid <= deq_pop && head_writes_rd;
            if (deq_pop && head_op == op_ebreak) begin
                halt <= 1'b1;
            end
        end
    end

    // writeback payload, qualified by wb_valid
    always_ff @(posedge CLK) begin
        if (deq_pop) begin
            wb_rd   <= head_rd;
            wb_data <= alu_result;
        end
    end

    // nothing retires once halted
    a_quiet_after_halt: assert property (@(posedge CLK) disable iff (!rst_n)
        halt |-> !wb_valid);

endmodule

//--- rtl/uop_pipe_top.sv
// ##########################################################################
// pipeline top: fetch, decode, micro-op queue, execute and register file
// ##########################################################################
module uop_pipe_top (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  uop_pkg::word_t    instr,
    output logic              instr_credit,
    output logic              wb_valid,
    output uop_pkg::reg_idx_t wb_rd,
    output uop_pkg::word_t    wb_data,
    output logic              halt
);
    import uop_pkg::*;

    // fetch to decode
    logic  fetch_valid;
    word_t fetch_instr;
    pc_t   fetch_pc;
    logic  fetch_pop;

    // decode to queue
    logic     enq_valid;
    alu_op_t  uop_op;
    reg_idx_t uop_rd;
    reg_idx_t uop_rs1;
    reg_idx_t uop_rs2;
    imm_t     uop_imm;
    logic     uop_use_imm;
    logic     uop_writes_rd;
    pc_t      uop_pc;
    logic     uop_credit;

    // queue head to execute
    logic     deq_ready;
    logic     deq_pop;
    alu_op_t  head_op;
    reg_idx_t head_rd;
    reg_idx_t head_rs1;
    reg_idx_t head_rs2;
    imm_t     head_imm;
    logic     head_use_imm;
    logic     head_writes_rd;
    pc_t      head_pc;

    // register file reads
    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;

    fetch_stage fetch_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .fetch_pop    (fetch_pop)
    );

    decode_stage decode_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_instr   (fetch_instr),
        .fetch_pc      (fetch_pc),
        .fetch_pop     (fetch_pop),
        .enq_valid     (enq_valid),
        .uop_op        (uop_op),
        .uop_rd        (uop_rd),
        .uop_rs1       (uop_rs1),
        .uop_rs2       (uop_rs2),
        .uop_imm       (uop_imm),
        .uop_use_imm   (uop_use_imm),
        .uop_writes_rd (uop_writes_rd),
        .uop_pc        (uop_pc),
        .uop_credit    (uop_credit)
    );

    uop_queue queue_i (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .enq_valid      (enq_valid),
        .uop_op         (uop_op),
        .uop_rd         (uop_rd),
        .uop_rs1        (uop_rs1),
        .uop_rs2        (uop_rs2),
        .uop_imm        (uop_imm),
        .uop_use_imm    (uop_use_imm),
        .uop_writes_rd  (uop_writes_rd),
        .uop_pc         (uop_pc),
        .deq_ready      (deq_ready),
        .deq_pop        (deq_pop),
        .head_op        (head_op),
        .head_rd        (head_rd),
        .head_rs1       (head_rs1),
        .head_rs2       (head_rs2),
        .head_imm       (head_imm),
        .head_use_imm   (head_use_imm),
        .head_writes_rd (head_writes_rd),
        .head_pc        (head_pc),
        .uop_credit     (uop_credit)
    );

    execute_stage execute_i (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .deq_ready      (deq_ready),
        .deq_pop        (deq_pop),
        .head_op        (head_op),
        .head_rd        (head_rd),
        .head_rs1       (head_rs1),
        .head_rs2       (head_rs2),
        .head_imm       (head_imm),
        .head_use_imm   (head_use_imm),
        .head_writes_rd (head_writes_rd),
        .head_pc        (head_pc),
        .rf_rs1         (rf_rs1),
        .rf_rs2         (rf_rs2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .halt           (halt)
    );

    // file write port fed by the writeback register
    reg_file rf_i (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .rs1    (rf_rs1),
        .rs2    (rf_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

endmodule

//--- verification/uop_pipe_tb.sv
// ##########################################################################
// testbench for uop_pipe_top: instruction table, credit-honouring source,
// reference model, writeback monitor and watchdog
// ##########################################################################
module uop_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import uop_pkg::*;

    logic     CLK;
    logic     rst_n;
    logic     instr_valid;
    word_t    instr;
    logic     instr_credit;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     halt;

    // table columns, expected ones filled by the model
    word_t    tbl_instr [$];
    int       tbl_test [$];
    reg_idx_t tbl_exp_rd [$];
    word_t    tbl_exp_data [$];

    // table rows still owed a writeback, in program order
    int exp_idx [$];

    string test_name [6];
    int    test_expected [6];
    int    test_checked [6];
    int    test_fail [6];
    int    total_fail;
    int    num_checks;
    int    last_test;
    logic  halt_seen;
    logic  table_ready;

    // source side credit state
    int credits;
    int max_outstanding;

    uop_pipe_top dut (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .halt         (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // rv32i encoders
    function automatic word_t enc_itype(input logic [6:0] opc, input logic [2:0] f3,
                                        input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input reg_idx_t rd, input reg_idx_t rs1,
                                        input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_utype(input logic [6:0] opc, input reg_idx_t rd,
                                        input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    task automatic add_entry(input int test_id, input word_t w);
        tbl_instr.push_back(w);
        tbl_test.push_back(test_id);
        tbl_exp_rd.push_back('0);
        tbl_exp_data.push_back('0);
    endtask

    task automatic build_table();
        test_name[1] = "alu ops";
        test_name[2] = "forwarding and x0";
        test_name[3] = "lui and auipc";
        test_name[4] = "credit flow";
        test_name[5] = "unsupported and halt";
        // register and immediate alu
        add_entry(1, enc_itype(7'h13, 3'd0, 5'd1, 5'd0, 12'd100));
        add_entry(1, enc_itype(7'h13, 3'd0, 5'd2, 5'd0, 12'hff9));
        add_entry(1, enc_itype(7'h13, 3'd7, 5'd3, 5'd1, 12'h0f0));
        add_entry(1, enc_itype(7'h13, 3'd6, 5'd4, 5'd2, 12'h123));
        add_entry(1, enc_itype(7'h13, 3'd4, 5'd5, 5'd1, 12'h7ff));
        add_entry(1, enc_rtype(7'h00, 3'd0, 5'd6, 5'd1, 5'd2));
        add_entry(1, enc_rtype(7'h20, 3'd0, 5'd7, 5'd1, 5'd2));
        add_entry(1, enc_rtype(7'h00, 3'd7, 5'd8, 5'd2, 5'd4));
        add_entry(1, enc_rtype(7'h00, 3'd6, 5'd9, 5'd3, 5'd5));
        add_entry(1, enc_rtype(7'h00, 3'd4, 5'd10, 5'd6, 5'd7));
        // addi chain on x11 fed without gaps, then x0 as target and source
        add_entry(2, enc_itype(7'h13, 3'd0, 5'd11, 5'd0, 12'd1));
        add_entry(2, enc_itype(7'h13, 3'd0, 5'd11, 5'd11, 12'd1));
        add_entry(2, enc_itype(7'h13, 3'd0, 5'd11, 5'd11, 12'd1));
        add_entry(2, enc_itype(7'h13, 3'd0, 5'd11, 5'd11, 12'd1));
        add_entry(2, enc_rtype(7'h00, 3'd0, 5'd12, 5'd11, 5'd11));
        add_entry(2, enc_itype(7'h13, 3'd0, 5'd0, 5'd12, 12'd55));
        add_entry(2, enc_rtype(7'h00, 3'd0, 5'd13, 5'd0, 5'd12));
        add_entry(2, enc_rtype(7'h20, 3'd0, 5'd14, 5'd0, 5'd11));
        // upper immediates
        add_entry(3, enc_utype(7'h37, 5'd15, 20'h12345));
        add_entry(3, enc_utype(7'h17, 5'd16, 20'h00001));
        add_entry(3, enc_utype(7'h17, 5'd17, 20'h00000));
        add_entry(3, enc_itype(7'h13, 3'd0, 5'd18, 5'd15, 12'h678));
        // fed without gaps
        add_entry(4, enc_itype(7'h13, 3'd0, 5'd19, 5'd18, 12'd1));
        add_entry(4, enc_rtype(7'h00, 3'd0, 5'd20, 5'd19, 5'd16));
        add_entry(4, enc_rtype(7'h00, 3'd4, 5'd21, 5'd20, 5'd3));
        add_entry(4, enc_rtype(7'h20, 3'd0, 5'd22, 5'd21, 5'd14));
        add_entry(4, enc_rtype(7'h00, 3'd6, 5'd23, 5'd22, 5'd9));
        add_entry(4, enc_itype(7'h13, 3'd7, 5'd24, 5'd23, 12'h3c5));
        add_entry(4, enc_itype(7'h13, 3'd4, 5'd25, 5'd24, 12'hfff));
        add_entry(4, enc_rtype(7'h00, 3'd0, 5'd26, 5'd25, 5'd19));
        // opcode 7f and a load, then ebreak and words that must not retire
        add_entry(5, 32'hffffffff);
        add_entry(5, enc_itype(7'h03, 3'd2, 5'd5, 5'd1, 12'd0));
        add_entry(5, 32'h00100073);
        add_entry(5, enc_itype(7'h13, 3'd0, 5'd27, 5'd0, 12'd9));
        add_entry(5, enc_rtype(7'h00, 3'd0, 5'd28, 5'd1, 5'd2));
        add_entry(5, enc_utype(7'h37, 5'd29, 20'habcde));
    endtask

    // architectural model over the whole table
    task automatic run_model();
        word_t      mregs [32];
        pc_t        pc;
        logic       stopped;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      immi;
        word_t      immu;
        word_t      val;
        logic       wr;
        reg_idx_t   rd;
        logic [2:0] f3;
        logic [6:0] f7;
        int         i;
        pc = RESET_PC;
        stopped = 1'b0;
        for (i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        for (i = 0; i < tbl_instr.size(); i++) begin
            w = tbl_instr[i];
            rd = w[11:7];
            f3 = w[14:12];
            f7 = w[31:25];
            a = mregs[w[19:15]];
            b = mregs[w[24:20]];
            immi = {{20{w[31]}}, w[31:20]};
            immu = {w[31:12], 12'h000};
            wr = !stopped;
            val = '0;
            case (w[6:0])
                7'h33: begin
                    case ({f7, f3})
                        {7'h00, 3'd0}: val = a + b;
                        {7'h20, 3'd0}: val = a - b;
                        {7'h00, 3'd4}: val = a ^ b;
                        {7'h00, 3'd6}: val = a | b;
                        {7'h00, 3'd7}: val = a & b;
                        default:       wr = 1'b0;
                    endcase
                end
                7'h13: begin
                    case (f3)
                        3'd0:    val = a + immi;
                        3'd4:    val = a ^ immi;
                        3'd6:    val = a | immi;
                        3'd7:    val = a & immi;
                        default: wr = 1'b0;
                    endcase
                end
                7'h37: val = immu;
                7'h17: val = pc + immu;
                default: wr = 1'b0;
            endcase
            // x0 keeps zero and never reaches the write port
            if (wr && rd != 5'd0) begin
                mregs[rd] = val;
                tbl_exp_rd[i] = rd;
                tbl_exp_data[i] = val;
                exp_idx.push_back(i);
                test_expected[tbl_test[i]]++;
            end
            if (w == 32'h00100073) begin
                stopped = 1'b1;
            end
            pc = pc + 32'd4;
        end
    endtask

    task automatic check_reg(input int test_id, input string sig,
                             input reg_idx_t expected, input reg_idx_t actual);
        num_checks++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s expected=x%0d actual=x%0d",
                     $time, sig, expected, actual);
            test_fail[test_id]++;
            total_fail++;
        end
    endtask

    task automatic check_word(input int test_id, input string sig,
                              input word_t expected, input word_t actual);
        num_checks++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h",
                     $time, sig, expected, actual);
            test_fail[test_id]++;
            total_fail++;
        end
    endtask

    task automatic report_failure(input int test_id, input string what);
        $display("error at %0t: %s", $time, what);
        test_fail[test_id]++;
        total_fail++;
    endtask

    // one source cycle, credit returns usable from the next cycle on
    task automatic source_cycle(input logic send, input word_t w);
        logic got_credit;
        @(negedge CLK);
        got_credit = instr_credit;
        instr_valid = send;
        instr = send ? w : '0;
        if (send) begin
            credits--;
            if (FETCH_DEPTH - credits > max_outstanding) begin
                max_outstanding = FETCH_DEPTH - credits;
            end
        end
        if (got_credit) begin
            credits++;
            if (credits > FETCH_DEPTH) begin
                report_failure(4, "credit returned with no word outstanding");
            end
        end
    endtask

    // writeback monitor, sampled mid-cycle
    always @(negedge CLK) begin
        int idx;
        int t;
        if (rst_n && wb_valid) begin
            if (halt_seen) begin
                report_failure(5, "writeback after halt");
            end else if (exp_idx.size() == 0) begin
                report_failure(last_test, "writeback with no result expected");
            end else begin
                idx = exp_idx.pop_front();
                t = tbl_test[idx];
                last_test = t;
                check_reg(t, "wb_rd", tbl_exp_rd[idx], wb_rd);
                check_word(t, "wb_data", tbl_exp_data[idx], wb_data);
                test_checked[t]++;
                if (t <= 3 && test_checked[t] == test_expected[t]) begin
                    $display("test %0d %s: %0d results, %0d failures",
                             t, test_name[t], test_checked[t], test_fail[t]);
                end
            end
        end
        if (rst_n && halt && !halt_seen) begin
            halt_seen = 1'b1;
            if (exp_idx.size() != 0) begin
                report_failure(5, "halt raised before earlier results retired");
            end
        end else if (halt_seen && !halt) begin
            report_failure(5, "halt dropped before reset");
        end
    end

    // watchdog
    initial begin
        int limit;
        int cycle_cnt;
        wait (table_ready);
        limit = 20 * tbl_instr.size() + 100;
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: results missing after %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int i;
        int gap;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        total_fail = 0;
        num_checks = 0;
        last_test = 1;
        halt_seen = 1'b0;
        table_ready = 1'b0;
        credits = FETCH_DEPTH;
        max_outstanding = 0;
        for (i = 0; i < 6; i++) begin
            test_expected[i] = 0;
            test_checked[i] = 0;
            test_fail[i] = 0;
        end
        void'($urandom(58));
        build_table();
        run_model();
        table_ready = 1'b1;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        for (i = 0; i < tbl_instr.size(); i++) begin
            // burst rows get no idle gap
            gap = (tbl_test[i] == 2 || tbl_test[i] == 4) ? 0 : $urandom_range(3, 0);
            repeat (gap) source_cycle(1'b0, '0);
            while (credits == 0) begin
                source_cycle(1'b0, '0);
            end
            source_cycle(1'b1, tbl_instr[i]);
        end
        while (!halt) begin
            source_cycle(1'b0, '0);
        end
        // quiet window after halt
        repeat (50) source_cycle(1'b0, '0);

        if (exp_idx.size() != 0) begin
            report_failure(4, $sformatf("%0d results never written back", exp_idx.size()));
        end
        $display("test 4 %s: %0d entries accepted, max outstanding %0d, %0d failures",
                 test_name[4], tbl_instr.size(), max_outstanding, test_fail[4]);
        $display("test 5 %s: halt held 50 cycles, %0d failures",
                 test_name[5], test_fail[5]);
        $display("done: %0d checks, %0d failures", num_checks, total_fail);
        if (total_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- uop_pipe.f
common/uop_pkg.sv
rtl/reg_file.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
queue/uop_queue.sv
execute/execute_stage.sv
rtl/uop_pipe_top.sv
verification/uop_pipe_tb.sv
